//--- sources.f
verilog/msg_pkg.sv
verilog/net_cfg_pkg.sv
verilog/msg_chnl_if.sv
verilog/msg_source.sv
verilog/msg_merge_2to1.sv
verilog/msg_checker.sv
verilog/io_2to1_top.sv
testbench/io_2to1_properties.sv
testbench/io_2to1_tb.sv

//--- Makefile
SRCS := $(wildcard verilog/*.sv testbench/*.sv)

obj_dir/Vio_2to1_tb: sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module io_2to1_tb -Mdir obj_dir

run: obj_dir/Vio_2to1_tb
	./obj_dir/Vio_2to1_tb > sim.log 2>&1; cat sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- testbench/io_2to1_tb.sv
`timescale 1ns/1ns
`default_nettype none

module io_2to1_tb;

	localparam int CLK_HALF = 50;
	localparam int DRIVE_DELAY = 10;
	// Sum of all wait budgets below stays well inside this
	localparam int WATCHDOG_CYCLES = 20000;
	localparam int DRAIN_LIMIT = 400;
	localparam int STABLE_CYCLES = 30;
	localparam int RUN_LIMIT = 1000;

	logic snk0_clk;
	logic rst_n;
	logic run;
	logic fault0;
	logic fault1;
	wire logic [3:0] err_leds;
	wire logic [3:0] disp0;
	wire logic [15:0] rcv_cnt0;
	wire logic [15:0] rcv_cnt1;

	int error_count;
	int check_count;
	logic [3:0] exp_disp;
	logic [15:0] prev_cnt0;
	logic [15:0] prev_cnt1;

	io_2to1_top dut_i (
		.snk0_clk(snk0_clk),
		.rst_n(rst_n),
		.run(run),
		.fault0(fault0),
		.fault1(fault1),
		.err_leds(err_leds),
		.disp0(disp0),
		.rcv_cnt0(rcv_cnt0),
		.rcv_cnt1(rcv_cnt1)
	);

	bind msg_merge_2to1 io_2to1_properties props_i (
		.snk0_clk(snk0_clk),
		.rst_n(rst_n),
		.out_valid(out_valid_q),
		.out_credits(out_credits),
		.fill0(fill[0]),
		.fill1(fill[1]),
		.ready(ready),
		.pop(pop),
		.grant(grant)
	);

	always #CLK_HALF snk0_clk = ~snk0_clk;

	// Last delivered sequence value, from the counter steps
	always @(negedge snk0_clk) begin
		if (!rst_n) begin
			exp_disp = 4'h0;
		end else begin
			if (rcv_cnt0 != prev_cnt0)
				exp_disp = rcv_cnt0[3:0] - 4'd1;
			if (rcv_cnt1 != prev_cnt1)
				exp_disp = rcv_cnt1[3:0] - 4'd1;
		end
		prev_cnt0 = rcv_cnt0;
		prev_cnt1 = rcv_cnt1;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge snk0_clk);
		$display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

	task automatic advance_cycles(input int n);
		repeat (n) @(posedge snk0_clk);
		#DRIVE_DELAY;
	endtask

	task automatic report_mismatch(input string test, input string what, input int exp,
		input int act);
		error_count++;
		$display("Error %s: %s expected %0d, actual %0d", test, what, exp, act);
	endtask

	task automatic report_failure(input string test, input string what);
		error_count++;
		$display("Failure in %s: %s", test, what);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		run = 1'b0;
		fault0 = 1'b0;
		fault1 = 1'b0;
		advance_cycles(2);
		rst_n = 1'b1;
		advance_cycles(1);
	endtask

	// Counters are drained once they hold still for a while
	task automatic wait_drained(input string test);
		int stable;
		int n;
		logic [15:0] last0;
		logic [15:0] last1;
		stable = 0;
		n = 0;
		last0 = rcv_cnt0;
		last1 = rcv_cnt1;
		while (stable < STABLE_CYCLES && n < DRAIN_LIMIT) begin
			advance_cycles(1);
			n++;
			if (rcv_cnt0 == last0 && rcv_cnt1 == last1)
				stable++;
			else
				stable = 0;
			last0 = rcv_cnt0;
			last1 = rcv_cnt1;
		end
		if (stable < STABLE_CYCLES)
			report_failure(test, "message counters kept changing after run went low");
	endtask

	task automatic reset_state();
		apply_reset();
		check_count += 4;
		if (err_leds !== 4'h0)
			report_mismatch("reset_state", "err_leds", 0, int'(err_leds));
		if (disp0 !== 4'h0)
			report_mismatch("reset_state", "disp0", 0, int'(disp0));
		if (rcv_cnt0 !== 16'h0)
			report_mismatch("reset_state", "rcv_cnt0", 0, int'(rcv_cnt0));
		if (rcv_cnt1 !== 16'h0)
			report_mismatch("reset_state", "rcv_cnt1", 0, int'(rcv_cnt1));
	endtask

	task automatic clean_stream();
		int diff;
		run = 1'b1;
		advance_cycles(300);
		run = 1'b0;
		wait_drained("clean_stream");
		diff = int'(rcv_cnt0) - int'(rcv_cnt1);
		check_count += 5;
		if (err_leds !== 4'h0)
			report_mismatch("clean_stream", "err_leds", 0, int'(err_leds));
		if (rcv_cnt0 == 16'h0)
			report_failure("clean_stream", "no message arrived from source 0");
		if (rcv_cnt1 == 16'h0)
			report_failure("clean_stream", "no message arrived from source 1");
		if (diff > 1 || diff < -1)
			report_failure("clean_stream", "source counters drifted apart by more than one");
		if (disp0 !== exp_disp)
			report_mismatch("clean_stream", "disp0", int'(exp_disp), int'(disp0));
	endtask

	// Forty more messages each, so the four-bit sequence wraps more than twice
	task automatic sequence_wrap();
		int n;
		logic [15:0] goal0;
		logic [15:0] goal1;
		goal0 = rcv_cnt0 + 16'd40;
		goal1 = rcv_cnt1 + 16'd40;
		n = 0;
		run = 1'b1;
		while ((rcv_cnt0 <= goal0 || rcv_cnt1 <= goal1) && n < RUN_LIMIT) begin
			advance_cycles(1);
			n++;
		end
		check_count += 3;
		if (rcv_cnt0 <= goal0 || rcv_cnt1 <= goal1)
			report_failure("sequence_wrap", "counters did not advance by forty in time");
		if (rcv_cnt0 <= 16'd40 || rcv_cnt1 <= 16'd40)
			report_failure("sequence_wrap", "a counter did not pass forty");
		if (err_leds !== 4'h0)
			report_mismatch("sequence_wrap", "err_leds", 0, int'(err_leds));
	endtask

	task automatic stall_hold();
		logic [15:0] held0;
		logic [15:0] held1;
		bit moved;
		bit lit;
		run = 1'b0;
		wait_drained("stall_hold");
		held0 = rcv_cnt0;
		held1 = rcv_cnt1;
		moved = 1'b0;
		lit = 1'b0;
		repeat (100) begin
			advance_cycles(1);
			if (rcv_cnt0 != held0 || rcv_cnt1 != held1)
				moved = 1'b1;
			if (err_leds !== 4'h0)
				lit = 1'b1;
		end
		check_count += 2;
		if (moved)
			report_failure("stall_hold", "a counter moved while run was low");
		if (lit)
			report_failure("stall_hold", "an error light came on while stalled");
	endtask

	// Fault high from run rising until the first message is sealed
	task automatic run_with_fault(input string test, input int which, input logic [3:0] exp_err);
		int n;
		logic [15:0] start0;
		logic [15:0] start1;
		start0 = rcv_cnt0;
		start1 = rcv_cnt1;
		run = 1'b1;
		if (which == 0)
			fault0 = 1'b1;
		else
			fault1 = 1'b1;
		advance_cycles(3);
		fault0 = 1'b0;
		fault1 = 1'b0;
		n = 0;
		while ((rcv_cnt0 <= start0 + 16'd10 || rcv_cnt1 <= start1 + 16'd10) &&
			n < RUN_LIMIT) begin
			advance_cycles(1);
			n++;
		end
		run = 1'b0;
		wait_drained(test);
		check_count += 2;
		if (err_leds !== exp_err)
			report_mismatch(test, "err_leds", int'(exp_err), int'(err_leds));
		if ((which == 0 && rcv_cnt1 <= start1 + 16'd10) ||
			(which == 1 && rcv_cnt0 <= start0 + 16'd10))
			report_failure(test, "the healthy source stopped delivering");
	endtask

	task automatic fault_source0();
		run_with_fault("fault_source0", 0, 4'b1001);
	endtask

	task automatic fault_source1();
		apply_reset();
		run_with_fault("fault_source1", 1, 4'b1010);
	endtask

	initial begin
		snk0_clk = 1'b0;
		rst_n = 1'b0;
		run = 1'b0;
		fault0 = 1'b0;
		fault1 = 1'b0;
		error_count = 0;
		check_count = 0;
		exp_disp = 4'h0;
		prev_cnt0 = 16'h0;
		prev_cnt1 = 16'h0;

		reset_state();
		clean_stream();
		sequence_wrap();
		stall_hold();
		fault_source0();
		fault_source1();

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/io_2to1_properties.sv
`timescale 1ns/1ns
`default_nettype none

module io_2to1_properties (
	input wire logic snk0_clk,
	input wire logic rst_n,
	input wire logic out_valid,
	input wire logic [net_cfg_pkg::CRED_W-1:0] out_credits,
	input wire logic [net_cfg_pkg::CRED_W-1:0] fill0,
	input wire logic [net_cfg_pkg::CRED_W-1:0] fill1,
	input wire logic [1:0] ready,
	input wire logic [1:0] pop,
	input wire logic grant
);

	logic both_pop;
	logic prev_both;
	logic prev_grant;

	// Both inputs waiting and one of them forwarded
	assign both_pop = (ready == 2'b11) && (pop != 2'b00);

	// Previous forward, however many idle cycles lie between
	always_ff @(posedge snk0_clk) begin
		if (!rst_n) begin
			prev_both <= 1'b0;
			prev_grant <= 1'b0;
		end else if (pop != 2'b00) begin
			prev_both <= (ready == 2'b11);
			prev_grant <= grant;
		end
	end

	a_valid_needs_credit: assert property (@(posedge snk0_clk) disable iff (!rst_n)
		out_valid |-> (out_credits != '0))
		else $error("merge output valid with no sink credit");

	a_out_credit_bound: assert property (@(posedge snk0_clk) disable iff (!rst_n)
		out_credits <= net_cfg_pkg::SINK_CRED_INIT)
		else $error("merge output credits above sink depth");

	a_fill_bound: assert property (@(posedge snk0_clk) disable iff (!rst_n)
		(fill0 <= net_cfg_pkg::MERGE_CRED_INIT) && (fill1 <= net_cfg_pkg::MERGE_CRED_INIT))
		else $error("merge input buffer above its depth");

	a_grant_alternates: assert property (@(posedge snk0_clk) disable iff (!rst_n)
		(both_pop && prev_both) |-> (grant != prev_grant))
		else $error("merge granted the same input twice while both waited");

endmodule

`default_nettype wire

//--- verilog/io_2to1_top.sv
`timescale 1ns/1ns
`default_nettype none

module io_2to1_top (
	input wire logic snk0_clk,
	input wire logic rst_n,
	input wire logic run,
	input wire logic fault0,
	input wire logic fault1,
	output wire logic [3:0] err_leds,
	output wire logic [3:0] disp0,
	output wire logic [15:0] rcv_cnt0,
	output wire logic [15:0] rcv_cnt1
);

	// Sources to merge inputs, then merge to the sink
	msg_chnl_if #(.payload_t(msg_pkg::msg_t)) src0_ch ();
	msg_chnl_if #(.payload_t(msg_pkg::msg_t)) src1_ch ();
	msg_chnl_if #(.payload_t(msg_pkg::msg_t)) sink_ch ();

	msg_source #(
		.SRC_ADDR(net_cfg_pkg::SRC0_ADDR)
	) src0_i (
		.snk0_clk(snk0_clk),
		.rst_n(rst_n),
		.run(run),
		.fault(fault0),
		.tx(src0_ch.tx)
	);

	msg_source #(
		.SRC_ADDR(net_cfg_pkg::SRC1_ADDR)
	) src1_i (
		.snk0_clk(snk0_clk),
		.rst_n(rst_n),
		.run(run),
		.fault(fault1),
		.tx(src1_ch.tx)
	);

	msg_merge_2to1 #(
		.payload_t(msg_pkg::msg_t)
	) merge_i (
		.snk0_clk(snk0_clk),
		.rst_n(rst_n),
		.in0(src0_ch.rx),
		.in1(src1_ch.rx),
		.out(sink_ch.tx)
	);

	msg_checker chk_i (
		.snk0_clk(snk0_clk),
		.rst_n(rst_n),
		.rx(sink_ch.rx),
		.err_leds(err_leds),
		.disp0(disp0),
		.rcv_cnt0(rcv_cnt0),
		.rcv_cnt1(rcv_cnt1)
	);

endmodule

`default_nettype wire

//--- verilog/msg_checker.sv
`timescale 1ns/1ns
`default_nettype none

module msg_checker (
	input wire logic snk0_clk,
	input wire logic rst_n,
	msg_chnl_if.rx rx,
	output logic [3:0] err_leds,
	output logic [3:0] disp0,
	output logic [15:0] rcv_cnt0,
	output logic [15:0] rcv_cnt1
);

	msg_pkg::msg_t mem [net_cfg_pkg::SINK_CREDITS];
	logic [net_cfg_pkg::SINK_PTR_W-1:0] wr_ptr;
	logic [net_cfg_pkg::SINK_PTR_W-1:0] rd_ptr;
	logic [net_cfg_pkg::CRED_W-1:0] fill;
	msg_pkg::msg_t head;
	logic phase;
	logic pop;
	logic credit_q;
	logic [msg_pkg::SEQ_W-1:0] exp_seq0;
	logic [msg_pkg::SEQ_W-1:0] exp_seq1;
	logic [msg_pkg::SEQ_W-1:0] head_seq;

	// Verdicts from the first check cycle
	logic red_bad_q;
	logic seq_bad_q;
	logic addr_bad_q;
	logic from0_q;
	logic from1_q;

	assign head = mem[rd_ptr];
	assign head_seq = head.dat[msg_pkg::SEQ_W-1:0];
	// Second check cycle releases the slot
	assign pop = phase;
	assign rx.credit = credit_q;

	always_ff @(posedge snk0_clk) begin
		if (rx.valid)
			mem[wr_ptr] <= rx.msg;
		if (!phase && (fill != '0)) begin
			red_bad_q <= (head.red != msg_pkg::calc_redun(head));
			from0_q <= (head.src == net_cfg_pkg::SRC0_ADDR);
			from1_q <= (head.src == net_cfg_pkg::SRC1_ADDR);
			seq_bad_q <= (head.src == net_cfg_pkg::SRC0_ADDR) ?
				(head_seq != exp_seq0) : (head_seq != exp_seq1);
			addr_bad_q <= (head.dst < net_cfg_pkg::MIN_ADDR) ||
				(head.dst > net_cfg_pkg::MAX_ADDR) ||
				((head.src != net_cfg_pkg::SRC0_ADDR) &&
				(head.src != net_cfg_pkg::SRC1_ADDR));
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			phase <= 1'b0;
			credit_q <= 1'b0;
			exp_seq0 <= '0;
			exp_seq1 <= '0;
			err_leds <= 4'h0;
			disp0 <= 4'h0;
			rcv_cnt0 <= 16'h0000;
			rcv_cnt1 <= 16'h0000;
		end else begin
			if (rx.valid)
				wr_ptr <= wr_ptr + 1;
			case ({rx.valid, pop})
				2'b10: fill <= fill + 1;
				2'b01: fill <= fill - 1;
				default: fill <= fill;
			endcase
			credit_q <= pop;
			if (!phase) begin
				if (fill != '0)
					phase <= 1'b1;
			end else begin
				phase <= 1'b0;
				rd_ptr <= rd_ptr + 1;
				disp0 <= head.dat[3:0];
				// Expected value moves on even after a bad code
				if (from0_q) begin
					rcv_cnt0 <= rcv_cnt0 + 1;
					exp_seq0 <= (exp_seq0 == net_cfg_pkg::SEQ_WRAP) ? '0 : exp_seq0 + 1;
					err_leds[0] <= err_leds[0] | red_bad_q | seq_bad_q;
				end
				if (from1_q) begin
					rcv_cnt1 <= rcv_cnt1 + 1;
					exp_seq1 <= (exp_seq1 == net_cfg_pkg::SEQ_WRAP) ? '0 : exp_seq1 + 1;
					err_leds[1] <= err_leds[1] | red_bad_q | seq_bad_q;
				end
				err_leds[2] <= err_leds[2] | addr_bad_q;
				err_leds[3] <= err_leds[3] | red_bad_q;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/msg_merge_2to1.sv
`timescale 1ns/1ns
`default_nettype none

module msg_merge_2to1 #(
	parameter type payload_t = logic
) (
	input wire logic snk0_clk,
	input wire logic rst_n,
	msg_chnl_if.rx in0,
	msg_chnl_if.rx in1,
	msg_chnl_if.tx out
);

	logic [1:0] in_valid;
	payload_t in_msg [2];
	payload_t mem [2][net_cfg_pkg::MERGE_CREDITS];
	logic [net_cfg_pkg::MERGE_PTR_W-1:0] wr_ptr [2];
	logic [net_cfg_pkg::MERGE_PTR_W-1:0] rd_ptr [2];
	logic [net_cfg_pkg::CRED_W-1:0] fill [2];
	logic [1:0] ready;
	logic [1:0] pop;
	logic [1:0] credit_q;
	logic grant;
	logic rr_last;
	logic [net_cfg_pkg::CRED_W-1:0] out_credits;
	logic [net_cfg_pkg::CRED_W-1:0] out_free;
	logic out_valid_q;
	payload_t out_msg_q;

	assign in_valid = {in1.valid, in0.valid};
	assign in_msg[0] = in0.msg;
	assign in_msg[1] = in1.msg;
	assign in0.credit = credit_q[0];
	assign in1.credit = credit_q[1];

	assign out.valid = out_valid_q;
	assign out.msg = out_msg_q;

	// Credits left once the message already on the wire is counted
	assign out_free = out_credits - {{(net_cfg_pkg::CRED_W-1){1'b0}}, out_valid_q};

	always_comb begin
		for (int k = 0; k < 2; k++)
			ready[k] = (fill[k] != '0);
		// Round robin only matters when both inputs wait
		if (ready == 2'b11)
			grant = ~rr_last;
		else
			grant = ready[1];
		pop = 2'b00;
		if ((ready != 2'b00) && (out_free != '0))
			pop[grant] = 1'b1;
	end

	always_ff @(posedge snk0_clk) begin
		for (int k = 0; k < 2; k++) begin
			if (in_valid[k])
				mem[k][wr_ptr[k]] <= in_msg[k];
		end
		if (pop != 2'b00)
			out_msg_q <= mem[grant][rd_ptr[grant]];
	end

	always_ff @(posedge snk0_clk) begin
		if (!rst_n) begin
			for (int k = 0; k < 2; k++) begin
				wr_ptr[k] <= '0;
				rd_ptr[k] <= '0;
				fill[k] <= '0;
			end
			credit_q <= 2'b00;
			rr_last <= 1'b1;
			out_valid_q <= 1'b0;
		end else begin
			for (int k = 0; k < 2; k++) begin
				if (in_valid[k])
					wr_ptr[k] <= wr_ptr[k] + 1;
				if (pop[k])
					rd_ptr[k] <= rd_ptr[k] + 1;
				case ({in_valid[k], pop[k]})
					2'b10: fill[k] <= fill[k] + 1;
					2'b01: fill[k] <= fill[k] - 1;
					default: fill[k] <= fill[k];
				endcase
			end
			// Slot freed, credit goes back with the outgoing valid
			credit_q <= pop;
			out_valid_q <= (pop != 2'b00);
			if (pop != 2'b00)
				rr_last <= grant;
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (!rst_n) begin
			out_credits <= net_cfg_pkg::SINK_CRED_INIT;
		end else begin
			case ({out.credit, out_valid_q})
				2'b10: out_credits <= out_credits + 1;
				2'b01: out_credits <= out_credits - 1;
				default: out_credits <= out_credits;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/msg_source.sv
`timescale 1ns/1ns
`default_nettype none

module msg_source #(
	parameter logic [msg_pkg::ADDR_W-1:0] SRC_ADDR = net_cfg_pkg::SRC0_ADDR
) (
	input wire logic snk0_clk,
	input wire logic rst_n,
	input wire logic run,
	input wire logic fault,
	msg_chnl_if.tx tx
);

	typedef enum logic [1:0] {
		ST_DST,
		ST_DAT,
		ST_RED
	} state_t;

	state_t state;
	logic [msg_pkg::ADDR_W-1:0] dst_walk;
	logic [msg_pkg::SEQ_W-1:0] seq;
	logic [net_cfg_pkg::CRED_W-1:0] credits;
	logic valid_q;
	logic load_dst;
	logic send;
	logic [msg_pkg::REDUN_W-1:0] code;
	msg_pkg::msg_t msg_q;

	assign load_dst = (state == ST_DST) && run;
	assign send = (state == ST_RED) && (credits != '0);
	assign code = msg_pkg::calc_redun(msg_q);

	assign tx.valid = valid_q;
	assign tx.msg = msg_q;

	always_ff @(posedge snk0_clk) begin
		if (!rst_n) begin
			state <= ST_DST;
			dst_walk <= net_cfg_pkg::MIN_ADDR;
			seq <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= send;
			case (state)
				ST_DST: begin
					if (load_dst) begin
						state <= ST_DAT;
						if (dst_walk >= net_cfg_pkg::MAX_ADDR)
							dst_walk <= net_cfg_pkg::MIN_ADDR;
						else
							dst_walk <= dst_walk + 1;
					end
				end
				ST_DAT: begin
					state <= ST_RED;
					seq <= (seq == net_cfg_pkg::SEQ_WRAP) ? '0 : seq + 1;
				end
				default: begin
					// Held here until a credit is available
					if (send)
						state <= ST_DST;
				end
			endcase
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (load_dst) begin
			msg_q.src <= SRC_ADDR;
			msg_q.dst <= dst_walk;
		end
		if (state == ST_DAT)
			msg_q.dat <= {{(msg_pkg::DATA_W - msg_pkg::SEQ_W){1'b0}}, seq};
		if (send)
			msg_q.red <= fault ? ~code : code;
	end

	always_ff @(posedge snk0_clk) begin
		if (!rst_n) begin
			credits <= net_cfg_pkg::MERGE_CRED_INIT;
		end else begin
			case ({tx.credit, valid_q})
				2'b10: credits <= credits + 1;
				2'b01: credits <= credits - 1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/msg_chnl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface msg_chnl_if #(
	parameter type payload_t = logic
);

	// From the transmitter, valid lasts one cycle per message
	logic valid;
	payload_t msg;

	// From the receiver, one pulse per freed slot
	logic credit;

	modport tx (
		output valid,
		output msg,
		input credit
	);

	modport rx (
		input valid,
		input msg,
		output credit
	);

endinterface

`default_nettype wire

//--- verilog/net_cfg_pkg.sv
`default_nettype none

package net_cfg_pkg;

	// Destination range walked by every source
	localparam logic [msg_pkg::ADDR_W-1:0] MIN_ADDR = 1;
	localparam logic [msg_pkg::ADDR_W-1:0] MAX_ADDR = 3;

	localparam logic [msg_pkg::ADDR_W-1:0] SRC0_ADDR = 0;
	localparam logic [msg_pkg::ADDR_W-1:0] SRC1_ADDR = 1;

	// Buffer depths, powers of two so pointers wrap on their own
	localparam int MERGE_CREDITS = 2;
	localparam int SINK_CREDITS = 2;

	localparam int CRED_W = $clog2(((MERGE_CREDITS > SINK_CREDITS) ?
		MERGE_CREDITS : SINK_CREDITS) + 1);
	localparam logic [CRED_W-1:0] MERGE_CRED_INIT = CRED_W'(MERGE_CREDITS);
	localparam logic [CRED_W-1:0] SINK_CRED_INIT = CRED_W'(SINK_CREDITS);
	localparam int MERGE_PTR_W = (MERGE_CREDITS > 1) ? $clog2(MERGE_CREDITS) : 1;
	localparam int SINK_PTR_W = (SINK_CREDITS > 1) ? $clog2(SINK_CREDITS) : 1;

	localparam logic [msg_pkg::SEQ_W-1:0] SEQ_WRAP = 15;

endpackage

`default_nettype wire

//--- verilog/msg_pkg.sv
`default_nettype none

package msg_pkg;

	localparam int ADDR_W = 4;
	localparam int DATA_W = 8;
	// Sequence value sits in the low bits of dat
	localparam int SEQ_W = 4;
	localparam int REDUN_W = 4;

	typedef struct packed {
		logic [ADDR_W-1:0] src;
		logic [ADDR_W-1:0] dst;
		logic [DATA_W-1:0] dat;
		logic [REDUN_W-1:0] red;
	} msg_t;

	// XOR of every nibble of src, dst and dat
	function automatic logic [REDUN_W-1:0] calc_redun(input msg_t m);
		logic [REDUN_W-1:0] r;
		r = '0;
		for (int i = 0; i < ADDR_W / REDUN_W; i++) begin
			r = r ^ m.src[i*REDUN_W +: REDUN_W];
			r = r ^ m.dst[i*REDUN_W +: REDUN_W];
		end
		for (int i = 0; i < DATA_W / REDUN_W; i++) begin
			r = r ^ m.dat[i*REDUN_W +: REDUN_W];
		end
		return r;
	endfunction

endpackage

`default_nettype wire
